// ==== logic/rv_ctrl_pkg.sv ====
package rv_ctrl_pkg;

  // Major opcodes of the RV32 base encoding that the control path tells apart
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_OP_IMM = 7'b0010011;
  localparam logic [6:0] OP_OP     = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // An OP-format word with this funct7 is a multiply or divide
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  // Source of the value written back in WB
  localparam logic [2:0] RES_ALU  = 3'd0;
  localparam logic [2:0] RES_LOAD = 3'd1;
  localparam logic [2:0] RES_CSR  = 3'd2;
  localparam logic [2:0] RES_M    = 3'd3;
  localparam logic [2:0] RES_PC4  = 3'd4;

  // Next-PC choice reported to fetch
  localparam logic [1:0] PC_SEL_SEQ       = 2'd0;
  localparam logic [1:0] PC_SEL_PREDICTED = 2'd1;
  localparam logic [1:0] PC_SEL_REDIRECT  = 2'd2;

  // Forwarding network exists in the datapath
  localparam int FWD         = 1;
  // Register file returns the value being written in the same cycle
  localparam int FWD_REGFILE = 1;

  // Data memory flavour decides when load data can be forwarded
  localparam int MEM_TYPE_BRAM = 0;
  localparam int MEM_TYPE_SRAM = 1;
  localparam int MEM_TYPE      = MEM_TYPE_BRAM;

  // Cycles an M-extension op occupies EX
  localparam int M_CYCLES = 4;

  // One instruction word seen through the R and I layouts
  // Fields at the same bit positions agree between the two views
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
  } rv_instr_t;

endpackage

// ==== logic/rv_hazard.sv ====
`timescale 1ns/1ps

module rv_hazard import rv_ctrl_pkg::*; (
  // Register usage of the instruction waiting in ID
  input  logic [4:0] rs1_id,
  input  logic [4:0] rs2_id,
  input  logic       rs1_used_id,
  input  logic       rs2_used_id,
  input  logic       jal_id,

  // Instruction in EX
  input  logic [4:0] rd_ex,
  input  logic       reg_write_ex,
  input  logic       is_ld_ex,
  input  logic       is_csr_ex,
  input  logic       is_m_ex,
  input  logic       op_active_ex,
  input  logic       redir_ex,

  // Instructions in MEM and WB
  input  logic [4:0] rd_mem,
  input  logic       reg_write_mem,
  input  logic [2:0] res_src_mem,
  input  logic [4:0] rd_wb,
  input  logic       reg_write_wb,

  // Data memory back-pressure
  input  logic       stall_mem,

  output logic [1:0] pc_sel,
  output logic       data_hazard_id,
  output logic       if_id_flush,
  output logic       id_ex_flush,
  output logic       ex_mem_flush
);

  // True when a writer to rd feeds a source the ID instruction really reads
  // Writes to x0 never create a dependency
  function automatic logic src_hit(input logic [4:0] rd, input logic we,
                                   input logic [4:0] rs, input logic used);
    return used && we && (rd != 5'd0) && (rd == rs);
  endfunction

  logic ex_hazard;
  logic mem_hazard;
  logic wb_hazard;
  logic is_ld_mem;
  logic is_csr_mem;
  logic is_m_mem;
  logic late_ex;
  logic late_mem;
  logic raw_hazard;
  logic pred_taken;

  assign ex_hazard = src_hit(rd_ex, reg_write_ex, rs1_id, rs1_used_id) ||
                     src_hit(rd_ex, reg_write_ex, rs2_id, rs2_used_id);

  assign mem_hazard = src_hit(rd_mem, reg_write_mem, rs1_id, rs1_used_id) ||
                      src_hit(rd_mem, reg_write_mem, rs2_id, rs2_used_id);

  // A register file that forwards its own write port hides the WB stage
  assign wb_hazard = (FWD_REGFILE == 0) &&
                     (src_hit(rd_wb, reg_write_wb, rs1_id, rs1_used_id) ||
                      src_hit(rd_wb, reg_write_wb, rs2_id, rs2_used_id));

  // Result class of the MEM instruction comes from its WB source code
  assign is_ld_mem  = (res_src_mem == RES_LOAD);
  assign is_csr_mem = (res_src_mem == RES_CSR);
  assign is_m_mem   = (res_src_mem == RES_M);

  // CSR and M results are produced only on the way into WB
  // A load in EX has not reached the data memory yet with either memory type
  // BRAM returns load data one cycle after MEM so loads in MEM are late too
  // SRAM load data is already valid in MEM and can be forwarded from there
  assign late_ex  = is_csr_ex || is_m_ex || is_ld_ex;
  assign late_mem = is_csr_mem || is_m_mem ||
                    (is_ld_mem && (MEM_TYPE == MEM_TYPE_BRAM));

  always_comb begin
    if (FWD != 0) begin
      // Plain ALU results reach ID through the forwarding muxes
      raw_hazard = (late_ex && ex_hazard) || (late_mem && mem_hazard) || wb_hazard;
    end else begin
      // Without forwarding every in-flight writer blocks the reader
      raw_hazard = ex_hazard || mem_hazard || wb_hazard;
    end
  end

  // The instruction held in ID is about to be discarded by a redirect
  // so its dependency no longer matters
  assign data_hazard_id = raw_hazard && !redir_ex;

  // JAL target is known in ID. The jump is taken only once the JAL really
  // leaves ID, otherwise the refused fetch word would be lost for nothing
  assign pred_taken = jal_id && !data_hazard_id && !op_active_ex &&
                      !stall_mem && !redir_ex;

  always_comb begin
    pc_sel = PC_SEL_SEQ;
    if (redir_ex) begin
      pc_sel = PC_SEL_REDIRECT;
    end else if (pred_taken) begin
      pc_sel = PC_SEL_PREDICTED;
    end
  end

  // Any change of fetch path kills the word sitting in ID
  assign if_id_flush = redir_ex || pred_taken;

  // Wrong-path bubble into EX
  // While memory stalls the branch itself is still in EX and must stay there
  assign id_ex_flush = redir_ex && !stall_mem;

  // A multi-cycle op keeps EX busy and MEM receives bubbles meanwhile
  assign ex_mem_flush = op_active_ex;

endmodule

// ==== logic/rv_id_stage.sv ====
`timescale 1ns/1ps

module rv_id_stage import rv_ctrl_pkg::*; (
  input  logic       clk,
  input  logic       rst,

  // Fetch side
  input  logic       in_valid,
  input  rv_instr_t  in_instr,
  output logic       in_ready,

  // Toward EX
  input  logic       ex_ready,
  output logic       id_valid,
  output rv_instr_t  id_instr,
  output logic [4:0] id_rd,
  output logic       id_reg_write,
  output logic [2:0] id_res_src,
  output logic       id_is_branch,

  // Hazard unit interface
  input  logic       data_hazard_id,
  input  logic       if_id_flush,
  output logic [4:0] rs1_id,
  output logic [4:0] rs2_id,
  output logic       rs1_used_id,
  output logic       rs2_used_id,
  output logic       jal_id
);

  rv_instr_t  instr_q;
  logic       vld_q;
  logic       armed_q;
  logic       accept;
  logic       advance;
  logic [6:0] opcode;
  logic [2:0] funct3;

  // Opcode, funct3, rd and rs1 are read through the I layout
  // rs2 and funct7 only exist in the R layout
  assign opcode = instr_q.i_fmt.opcode;
  assign funct3 = instr_q.i_fmt.funct3;

  // The instruction moves to EX only once its operands are obtainable
  assign advance = vld_q && !data_hazard_id && ex_ready;

  // armed_q keeps fetch out for the first cycle after reset
  assign in_ready = armed_q && !if_id_flush && (!vld_q || advance);
  assign accept   = in_valid && in_ready;

  assign id_valid     = vld_q && !data_hazard_id;
  assign id_instr     = instr_q;
  assign id_rd        = instr_q.i_fmt.rd;
  assign rs1_id       = instr_q.i_fmt.rs1;
  assign rs2_id       = instr_q.r_fmt.rs2;
  assign jal_id       = vld_q && (opcode == OP_JAL);
  // Both conditional branches and JALR resolve their target in EX
  assign id_is_branch = (opcode == OP_BRANCH) || (opcode == OP_JALR);

  always_comb begin
    rs1_used_id  = 1'b0;
    rs2_used_id  = 1'b0;
    id_reg_write = 1'b0;
    id_res_src   = RES_ALU;

    case (opcode)
      OP_LOAD: begin
        rs1_used_id  = 1'b1;
        id_reg_write = 1'b1;
        id_res_src   = RES_LOAD;
      end
      OP_STORE, OP_BRANCH: begin
        rs1_used_id = 1'b1;
        rs2_used_id = 1'b1;
      end
      OP_JAL: begin
        id_reg_write = 1'b1;
        id_res_src   = RES_PC4;
      end
      OP_JALR: begin
        rs1_used_id  = 1'b1;
        id_reg_write = 1'b1;
        id_res_src   = RES_PC4;
      end
      OP_OP_IMM: begin
        // the rs2 slot holds immediate bits here
        rs1_used_id  = 1'b1;
        id_reg_write = 1'b1;
      end
      OP_OP: begin
        rs1_used_id  = 1'b1;
        rs2_used_id  = 1'b1;
        id_reg_write = 1'b1;
        if (instr_q.r_fmt.funct7 == FUNCT7_MULDIV) begin
          id_res_src = RES_M;
        end
      end
      OP_SYSTEM: begin
        // funct3 zero covers ECALL, EBREAK and MRET which write nothing
        // CSR forms with funct3[2] set carry an immediate in the rs1 slot
        rs1_used_id  = (funct3 != 3'd0) && !funct3[2];
        id_reg_write = (funct3 != 3'd0);
        id_res_src   = RES_CSR;
      end
      default: begin
      end
    endcase

    // A bubble in ID must not look like a reader
    if (!vld_q) begin
      rs1_used_id = 1'b0;
      rs2_used_id = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q   <= 1'b0;
      armed_q <= 1'b0;
    end else begin
      armed_q <= 1'b1;
      // A flush empties ID whether its instruction was wrong-path or already gone
      if (if_id_flush) begin
        vld_q <= 1'b0;
      end else if (accept) begin
        vld_q <= 1'b1;
      end else if (advance) begin
        vld_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      instr_q <= in_instr;
    end
  end

endmodule

// ==== logic/rv_back_pipe.sv ====
`timescale 1ns/1ps

module rv_back_pipe import rv_ctrl_pkg::*; (
  input  logic       clk,
  input  logic       rst,

  // From ID
  input  logic       id_valid,
  input  rv_instr_t  id_instr,
  input  logic [4:0] id_rd,
  input  logic       id_reg_write,
  input  logic [2:0] id_res_src,
  input  logic       id_is_branch,
  output logic       ex_ready,

  // Datapath status
  input  logic       br_taken_ex,
  input  logic       dmem_stall,

  // From the hazard unit
  input  logic       id_ex_flush,
  input  logic       ex_mem_flush,

  // EX state for the hazard unit
  output logic [4:0] rd_ex,
  output logic       reg_write_ex,
  output logic       is_ld_ex,
  output logic       is_csr_ex,
  output logic       is_m_ex,
  output logic       op_active_ex,
  output logic       redir_ex,

  // MEM and WB state for the hazard unit
  output logic [4:0] rd_mem,
  output logic       reg_write_mem,
  output logic [2:0] res_src_mem,
  output logic [4:0] rd_wb,
  output logic       reg_write_wb,

  // Retire port
  output logic       ret_valid,
  output rv_instr_t  ret_instr,
  output logic [4:0] ret_rd,
  output logic       ret_reg_write
);

  // EX stage
  logic                          ex_vld_q;
  rv_instr_t                     ex_instr_q;
  logic [4:0]                    ex_rd_q;
  logic                          ex_rw_q;
  logic [2:0]                    ex_res_q;
  logic                          ex_br_q;
  logic [$clog2(M_CYCLES)-1:0]   m_cnt_q;
  logic                          ex_take;

  // MEM stage
  logic       mem_vld_q;
  rv_instr_t  mem_instr_q;
  logic [4:0] mem_rd_q;
  logic       mem_rw_q;
  logic [2:0] mem_res_q;

  // WB stage
  logic       wb_vld_q;
  rv_instr_t  wb_instr_q;
  logic [4:0] wb_rd_q;
  logic       wb_rw_q;

  // EX is free when no M-op is still computing and memory is not holding MEM
  assign ex_ready = !op_active_ex && !dmem_stall;
  assign ex_take  = ex_ready && id_valid && !id_ex_flush;

  // Counter is loaded as an M-op enters and runs down to zero
  assign op_active_ex = (m_cnt_q != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_vld_q <= 1'b0;
      m_cnt_q  <= '0;
    end else begin
      if (ex_ready) begin
        ex_vld_q <= ex_take;
      end
      if (ex_take && (id_res_src == RES_M)) begin
        m_cnt_q <= $bits(m_cnt_q)'(M_CYCLES - 1);
      end else if (op_active_ex) begin
        m_cnt_q <= m_cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ex_take) begin
      ex_instr_q <= id_instr;
      ex_rd_q    <= id_rd;
      ex_rw_q    <= id_reg_write;
      ex_res_q   <= id_res_src;
      ex_br_q    <= id_is_branch;
    end
  end

  assign rd_ex        = ex_rd_q;
  assign reg_write_ex = ex_vld_q && ex_rw_q;
  assign is_ld_ex     = ex_vld_q && (ex_res_q == RES_LOAD);
  assign is_csr_ex    = ex_vld_q && (ex_res_q == RES_CSR);
  assign is_m_ex      = ex_vld_q && (ex_res_q == RES_M);

  // Branch outcome is only meaningful while a branch or JALR sits in EX
  assign redir_ex = ex_vld_q && ex_br_q && br_taken_ex;

  // MEM holds under back-pressure
  // It receives a bubble while EX is still working on an M-op
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_vld_q <= 1'b0;
    end else if (!dmem_stall) begin
      mem_vld_q <= ex_vld_q && !ex_mem_flush;
    end
  end

  always_ff @(posedge clk) begin
    if (!dmem_stall) begin
      mem_instr_q <= ex_instr_q;
      mem_rd_q    <= ex_rd_q;
      mem_rw_q    <= ex_rw_q;
      mem_res_q   <= ex_res_q;
    end
  end

  assign rd_mem        = mem_rd_q;
  assign reg_write_mem = mem_vld_q && mem_rw_q;
  assign res_src_mem   = mem_res_q;

  // WB drains every cycle
  // While MEM is held it gets a bubble so nothing retires twice
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_vld_q <= 1'b0;
    end else begin
      wb_vld_q <= mem_vld_q && !dmem_stall;
    end
  end

  always_ff @(posedge clk) begin
    if (!dmem_stall) begin
      wb_instr_q <= mem_instr_q;
      wb_rd_q    <= mem_rd_q;
      wb_rw_q    <= mem_rw_q;
    end
  end

  assign rd_wb        = wb_rd_q;
  assign reg_write_wb = wb_vld_q && wb_rw_q;

  // the WB register doubles as the retire port
  assign ret_valid     = wb_vld_q;
  assign ret_instr     = wb_instr_q;
  assign ret_rd        = wb_rd_q;
  assign ret_reg_write = wb_vld_q && wb_rw_q;

endmodule

// ==== logic/rv_pipe_ctrl.sv ====
`timescale 1ns/1ps

module rv_pipe_ctrl import rv_ctrl_pkg::*; (
  input  logic       clk,
  input  logic       rst,

  // Instruction stream from fetch
  input  logic       in_valid,
  input  rv_instr_t  in_instr,
  output logic       in_ready,

  // Datapath status
  input  logic       br_taken_ex,
  input  logic       dmem_stall,

  // Fetch control
  output logic [1:0] pc_sel,
  output logic       if_id_flush,

  // Retirement
  output logic       ret_valid,
  output rv_instr_t  ret_instr,
  output logic [4:0] ret_rd,
  output logic       ret_reg_write
);

  // ID to EX handoff
  logic       id_valid;
  rv_instr_t  id_instr;
  logic [4:0] id_rd;
  logic       id_reg_write;
  logic [2:0] id_res_src;
  logic       id_is_branch;
  logic       ex_ready;

  // ID register usage
  logic [4:0] rs1_id;
  logic [4:0] rs2_id;
  logic       rs1_used_id;
  logic       rs2_used_id;
  logic       jal_id;

  // Back pipeline state seen by the hazard unit
  logic [4:0] rd_ex;
  logic       reg_write_ex;
  logic       is_ld_ex;
  logic       is_csr_ex;
  logic       is_m_ex;
  logic       op_active_ex;
  logic       redir_ex;
  logic [4:0] rd_mem;
  logic       reg_write_mem;
  logic [2:0] res_src_mem;
  logic [4:0] rd_wb;
  logic       reg_write_wb;

  // Hazard decisions
  logic       data_hazard_id;
  logic       id_ex_flush;
  logic       ex_mem_flush;

  rv_id_stage id_stage_i (
    .clk            (clk),
    .rst            (rst),
    .in_valid       (in_valid),
    .in_instr       (in_instr),
    .in_ready       (in_ready),
    .ex_ready       (ex_ready),
    .id_valid       (id_valid),
    .id_instr       (id_instr),
    .id_rd          (id_rd),
    .id_reg_write   (id_reg_write),
    .id_res_src     (id_res_src),
    .id_is_branch   (id_is_branch),
    .data_hazard_id (data_hazard_id),
    .if_id_flush    (if_id_flush),
    .rs1_id         (rs1_id),
    .rs2_id         (rs2_id),
    .rs1_used_id    (rs1_used_id),
    .rs2_used_id    (rs2_used_id),
    .jal_id         (jal_id)
  );

  // Memory back-pressure is the only stall source for the hazard unit
  rv_hazard hazard_i (
    .rs1_id         (rs1_id),
    .rs2_id         (rs2_id),
    .rs1_used_id    (rs1_used_id),
    .rs2_used_id    (rs2_used_id),
    .jal_id         (jal_id),
    .rd_ex          (rd_ex),
    .reg_write_ex   (reg_write_ex),
    .is_ld_ex       (is_ld_ex),
    .is_csr_ex      (is_csr_ex),
    .is_m_ex        (is_m_ex),
    .op_active_ex   (op_active_ex),
    .redir_ex       (redir_ex),
    .rd_mem         (rd_mem),
    .reg_write_mem  (reg_write_mem),
    .res_src_mem    (res_src_mem),
    .rd_wb          (rd_wb),
    .reg_write_wb   (reg_write_wb),
    .stall_mem      (dmem_stall),
    .pc_sel         (pc_sel),
    .data_hazard_id (data_hazard_id),
    .if_id_flush    (if_id_flush),
    .id_ex_flush    (id_ex_flush),
    .ex_mem_flush   (ex_mem_flush)
  );

  rv_back_pipe back_pipe_i (
    .clk           (clk),
    .rst           (rst),
    .id_valid      (id_valid),
    .id_instr      (id_instr),
    .id_rd         (id_rd),
    .id_reg_write  (id_reg_write),
    .id_res_src    (id_res_src),
    .id_is_branch  (id_is_branch),
    .ex_ready      (ex_ready),
    .br_taken_ex   (br_taken_ex),
    .dmem_stall    (dmem_stall),
    .id_ex_flush   (id_ex_flush),
    .ex_mem_flush  (ex_mem_flush),
    .rd_ex         (rd_ex),
    .reg_write_ex  (reg_write_ex),
    .is_ld_ex      (is_ld_ex),
    .is_csr_ex     (is_csr_ex),
    .is_m_ex       (is_m_ex),
    .op_active_ex  (op_active_ex),
    .redir_ex      (redir_ex),
    .rd_mem        (rd_mem),
    .reg_write_mem (reg_write_mem),
    .res_src_mem   (res_src_mem),
    .rd_wb         (rd_wb),
    .reg_write_wb  (reg_write_wb),
    .ret_valid     (ret_valid),
    .ret_instr     (ret_instr),
    .ret_rd        (ret_rd),
    .ret_reg_write (ret_reg_write)
  );

endmodule

// ==== verif/rv_pipe_ctrl_checks.svh ====
  // Compare tasks for the DUT outputs and for cycle counts measured around them
  // Each prints the signal name with both values in hex on a mismatch

  task automatic check_instr(input string name, input rv_instr_t got, input rv_instr_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  // Destination register index
  task automatic check_rd(input string name, input logic [4:0] got, input logic [4:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR %s got 0x%02h expected 0x%02h", name, got, exp));
    end
  endtask

  // Single control or status bit
  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // Next-PC choice reported to fetch
  task automatic check_pc_sel(input string name, input logic [1:0] got,
                              input logic [1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // Cycle counts such as how long in_ready stayed low
  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      abort_run($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

// ==== verif/rv_pipe_ctrl_tb.sv ====
`timescale 1ns/1ps

module rv_pipe_ctrl_tb import rv_ctrl_pkg::*; ();

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 16;
  // ALU words in the opening stream
  localparam int N_STREAM     = 12;
  // Words sent by the load-use, M-op, branch and JAL tests together
  localparam int N_DIRECTED   = 29;
  localparam int WATCHDOG_NS  =
    (RESET_CYCLES + (N_STREAM + N_DIRECTED) * (M_CYCLES + 8)) * CLK_PERIOD;
  // BRAM load data becomes forwardable one stage later than SRAM data
  localparam int LOAD_USE_WAIT = (MEM_TYPE == MEM_TYPE_BRAM) ? 2 : 1;

  logic       clk = 1'b0;
  logic       rst = 1'b1;
  logic       in_valid = 1'b0;
  rv_instr_t  in_instr = '0;
  logic       in_ready;
  logic       br_taken_ex = 1'b0;
  logic       dmem_stall = 1'b0;
  logic [1:0] pc_sel;
  logic       if_id_flush;
  logic       ret_valid;
  rv_instr_t  ret_instr;
  logic [4:0] ret_rd;
  logic       ret_reg_write;

  // Stimulus state that only the main process writes
  logic [15:0] lfsr_q = 16'd15240;
  logic [11:0] tag_q = 12'h001;
  logic        stall_rand = 1'b0;

  // Reference queue and counters that only the monitor writes
  rv_instr_t ref_q[$];
  bit        dead_q[$];
  int        acc_q[$];
  int        live_cnt = 0;
  int        cycle_cnt = 0;
  int        redir_cnt = 0;
  int        pred_cnt = 0;
  int        last_lat = 0;
  logic      after_branch = 1'b0;

  rv_pipe_ctrl dut_i (
    .clk           (clk),
    .rst           (rst),
    .in_valid      (in_valid),
    .in_instr      (in_instr),
    .in_ready      (in_ready),
    .br_taken_ex   (br_taken_ex),
    .dmem_stall    (dmem_stall),
    .pc_sel        (pc_sel),
    .if_id_flush   (if_id_flush),
    .ret_valid     (ret_valid),
    .ret_instr     (ret_instr),
    .ret_rd        (ret_rd),
    .ret_reg_write (ret_reg_write)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "run stopped");
  endtask

  `include "rv_pipe_ctrl_checks.svh"

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[14:0], lfsr_q[0]};
    end
  endtask

  // A running tag in imm12 keeps every I-layout word distinct
  function automatic rv_instr_t i_word(input logic [6:0] opcode, input logic [2:0] funct3,
                                       input logic [4:0] rd, input logic [4:0] rs1);
    rv_instr_t w;
    w.i_fmt.imm12  = tag_q;
    w.i_fmt.rs1    = rs1;
    w.i_fmt.funct3 = funct3;
    w.i_fmt.rd     = rd;
    w.i_fmt.opcode = opcode;
    tag_q = tag_q + 12'd1;
    return w;
  endfunction

  function automatic rv_instr_t r_word(input logic [6:0] funct7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] funct3,
                                       input logic [4:0] rd, input logic [6:0] opcode);
    rv_instr_t w;
    w.r_fmt.funct7 = funct7;
    w.r_fmt.rs2    = rs2;
    w.r_fmt.rs1    = rs1;
    w.r_fmt.funct3 = funct3;
    w.r_fmt.rd     = rd;
    w.r_fmt.opcode = opcode;
    return w;
  endfunction

  // Stores and branches have no rd in RV32 and SYSTEM with funct3 zero writes nothing
  function automatic logic writes_rd(input rv_instr_t w);
    case (w.i_fmt.opcode)
      OP_LOAD, OP_JAL, OP_JALR, OP_OP_IMM, OP_OP: return 1'b1;
      OP_SYSTEM: return w.i_fmt.funct3 != 3'd0;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic resolves_in_ex(input rv_instr_t w);
    return (w.i_fmt.opcode == OP_BRANCH) || (w.i_fmt.opcode == OP_JALR);
  endfunction

  // Advance one clock and drive the memory stall for the coming cycle
  task automatic next_cycle;
    logic [15:0] r;
    @(posedge clk);
    if (stall_rand) begin
      draw_bits(1, r);
      dmem_stall <= r[0];
    end else begin
      dmem_stall <= 1'b0;
    end
  endtask

  // Offer one word and hold it until accepted while counting cycles with in_ready low
  task automatic send_word(input rv_instr_t w, output int waits);
    logic took;
    waits = 0;
    took = 1'b0;
    in_valid <= 1'b1;
    in_instr <= w;
    while (!took) begin
      @(negedge clk);
      took = in_ready;
      if (!took) begin
        waits++;
      end
      next_cycle();
    end
  endtask

  // Stop fetching and wait until every live word has retired plus some spare cycles
  task automatic wait_drain;
    in_valid <= 1'b0;
    while (live_cnt != 0) begin
      next_cycle();
    end
    repeat (6) next_cycle();
  endtask

  // Samples at the falling edge, where inputs and DUT outputs are settled
  always @(negedge clk) begin
    rv_instr_t exp_w;
    logic      dead;
    if (!rst) begin
      cycle_cnt++;
      if (pc_sel == PC_SEL_REDIRECT) begin
        redir_cnt++;
      end
      if (pc_sel == PC_SEL_PREDICTED) begin
        pred_cnt++;
        check_bit("in_ready", in_ready, 1'b0);
      end
      if (pc_sel != PC_SEL_SEQ) begin
        check_bit("if_id_flush", if_id_flush, 1'b1);
      end
      // A taken branch in EX kills the word fetched right behind it
      if (in_valid && in_ready) begin
        dead = after_branch && br_taken_ex;
        ref_q.push_back(in_instr);
        dead_q.push_back(dead);
        acc_q.push_back(cycle_cnt);
        if (!dead) begin
          live_cnt++;
        end
        after_branch = resolves_in_ex(in_instr);
      end
      if (ret_valid) begin
        while ((dead_q.size() != 0) && dead_q[0]) begin
          void'(ref_q.pop_front());
          void'(dead_q.pop_front());
          void'(acc_q.pop_front());
        end
        if (ref_q.size() == 0) begin
          abort_run("An instruction retired that was never accepted or should have been killed");
        end else begin
          exp_w = ref_q.pop_front();
          void'(dead_q.pop_front());
          last_lat = cycle_cnt - acc_q.pop_front();
          live_cnt--;
          check_instr("ret_instr", ret_instr, exp_w);
          check_rd("ret_rd", ret_rd, exp_w.i_fmt.rd);
          check_bit("ret_reg_write", ret_reg_write, writes_rd(exp_w));
        end
      end
    end
  end

  task automatic reset_and_stream;
    int          waits;
    logic [15:0] r;
    @(negedge clk);
    check_bit("ret_valid", ret_valid, 1'b0);
    check_bit("if_id_flush", if_id_flush, 1'b0);
    check_bit("in_ready", in_ready, 1'b0);
    check_pc_sel("pc_sel", pc_sel, PC_SEL_SEQ);
    next_cycle();
    stall_rand = 1'b1;
    for (int i = 0; i < N_STREAM; i++) begin
      draw_bits(4, r);
      // Destinations x1 to x12 all differ and sources come from x16 to x31
      send_word(i_word(OP_OP_IMM, 3'd0, 5'(i + 1), {1'b1, r[3:0]}), waits);
    end
    stall_rand = 1'b0;
    wait_drain();
  endtask

  task automatic load_use_stalls;
    int waits;
    send_word(i_word(OP_LOAD, 3'd2, 5'd5, 5'd1), waits);
    send_word(i_word(OP_OP_IMM, 3'd0, 5'd6, 5'd5), waits);
    check_count("consumer wait after load", waits, 0);
    send_word(i_word(OP_OP_IMM, 3'd0, 5'd7, 5'd0), waits);
    check_count("in_ready low cycles after load-use", waits, LOAD_USE_WAIT);
    wait_drain();
    // CSR results only appear on the way into WB with either memory type
    send_word(i_word(OP_SYSTEM, 3'd1, 5'd8, 5'd2), waits);
    send_word(i_word(OP_OP_IMM, 3'd0, 5'd9, 5'd8), waits);
    send_word(i_word(OP_OP_IMM, 3'd0, 5'd10, 5'd0), waits);
    check_count("in_ready low cycles after CSR-use", waits, 2);
    wait_drain();
    send_word(i_word(OP_LOAD, 3'd2, 5'd0, 5'd1), waits);
    send_word(i_word(OP_OP_IMM, 3'd0, 5'd11, 5'd0), waits);
    send_word(i_word(OP_OP_IMM, 3'd0, 5'd12, 5'd0), waits);
    check_count("in_ready low cycles after load to x0", waits, 0);
    wait_drain();
  endtask

  task automatic m_op_latency;
    int waits;
    int alu_lat;
    send_word(i_word(OP_OP_IMM, 3'd0, 5'd13, 5'd0), waits);
    wait_drain();
    alu_lat = last_lat;
    send_word(r_word(FUNCT7_MULDIV, 5'd3, 5'd4, 3'd0, 5'd14, OP_OP), waits);
    wait_drain();
    if (last_lat < alu_lat + M_CYCLES - 1) begin
      abort_run("M-op retired sooner than its extra EX cycles allow");
    end
    send_word(r_word(FUNCT7_MULDIV, 5'd3, 5'd4, 3'd4, 5'd15, OP_OP), waits);
    send_word(i_word(OP_OP_IMM, 3'd0, 5'd16, 5'd15), waits);
    wait_drain();
  endtask

  task automatic branch_kills;
    int waits;
    int redir0;
    br_taken_ex <= 1'b1;
    redir0 = redir_cnt;
    send_word(i_word(OP_OP_IMM, 3'd0, 5'd17, 5'd0), waits);
    send_word(r_word(7'h00, 5'd0, 5'd0, 3'd0, 5'd0, OP_BRANCH), waits);
    send_word(i_word(OP_OP_IMM, 3'd0, 5'd18, 5'd0), waits);
    send_word(i_word(OP_OP_IMM, 3'd0, 5'd19, 5'd0), waits);
    send_word(i_word(OP_OP_IMM, 3'd0, 5'd20, 5'd0), waits);
    wait_drain();
    check_count("redirect cycles with branch taken", redir_cnt - redir0, 1);
    br_taken_ex <= 1'b0;
    redir0 = redir_cnt;
    send_word(i_word(OP_OP_IMM, 3'd0, 5'd17, 5'd0), waits);
    send_word(r_word(7'h00, 5'd0, 5'd0, 3'd0, 5'd0, OP_BRANCH), waits);
    send_word(i_word(OP_OP_IMM, 3'd0, 5'd18, 5'd0), waits);
    send_word(i_word(OP_JALR, 3'd0, 5'd1, 5'd0), waits);
    send_word(i_word(OP_OP_IMM, 3'd0, 5'd19, 5'd0), waits);
    send_word(i_word(OP_OP_IMM, 3'd0, 5'd20, 5'd0), waits);
    wait_drain();
    check_count("redirect cycles with branch not taken", redir_cnt - redir0, 0);
  endtask

  task automatic jal_predicts;
    int waits;
    int pred0;
    pred0 = pred_cnt;
    send_word(i_word(OP_OP_IMM, 3'd0, 5'd21, 5'd0), waits);
    send_word(i_word(OP_JAL, 3'd0, 5'd1, 5'd0), waits);
    send_word(i_word(OP_OP_IMM, 3'd0, 5'd22, 5'd0), waits);
    check_count("in_ready low cycles after JAL", waits, 1);
    send_word(i_word(OP_JAL, 3'd0, 5'd0, 5'd0), waits);
    send_word(i_word(OP_OP_IMM, 3'd0, 5'd23, 5'd0), waits);
    check_count("in_ready low cycles after JAL", waits, 1);
    wait_drain();
    check_count("predicted cycles", pred_cnt - pred0, 2);
  endtask

  initial begin
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    reset_and_stream();
    load_use_stalls();
    m_op_latency();
    branch_kills();
    jal_predicts();
    if (live_cnt != 0) begin
      abort_run("Some accepted instructions never retired");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

  // Allows M_CYCLES + 8 cycles per word sent on top of reset
  initial begin
    #(WATCHDOG_NS);
    abort_run("Watchdog expired before the tests completed");
  end

endmodule

// ==== flist.f ====
+incdir+verif
logic/rv_ctrl_pkg.sv
logic/rv_hazard.sv
logic/rv_id_stage.sv
logic/rv_back_pipe.sv
logic/rv_pipe_ctrl.sv
verif/rv_pipe_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the pipeline control testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module rv_pipe_ctrl_tb -Mdir obj_dir -f flist.f
./obj_dir/Vrv_pipe_ctrl_tb 2>&1 | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
  echo "Simulation ended without a result, see sim.log"
  exit 1
fi
echo "Simulation passed"
